// File: hw/wb2sdrc_macros.svh
`ifndef WB2SDRC_MACROS_SVH
`define WB2SDRC_MACROS_SVH

`default_nettype none

// ----------------------------------------
// Bus widths
// ----------------------------------------

// Wishbone and SDRAM data width in bits
`define WB2SDRC_DW 32

// Application address width
`define WB2SDRC_AW 26

// ----------------------------------------
// Queue depths
// ----------------------------------------

// Commands waiting for the controller
`define WB2SDRC_CMD_DEPTH 4
// Write beats, data plus byte enables
`define WB2SDRC_WR_DEPTH 8
// Read data on its way back to Wishbone
`define WB2SDRC_RD_DEPTH 4

`default_nettype wire

`endif

// File: hw/wb2sdrc_pkg.sv
`include "wb2sdrc_macros.svh"

`default_nettype none

package wb2sdrc_pkg;

  // ----------------------------------------
  // Queue payloads
  // ----------------------------------------

  // One request to the SDRAM controller
  // Write flag is active low, as the controller expects
  typedef struct packed {
    logic                   wr_n;
    logic [`WB2SDRC_AW-1:0] addr;
  } sdr_cmd_t;

  // One write beat with active-low byte enables
  typedef struct packed {
    logic [`WB2SDRC_DW/8-1:0] en_n;
    logic [`WB2SDRC_DW-1:0]   data;
  } wr_beat_t;

  // ----------------------------------------
  // Control encodings
  // ----------------------------------------

  // Decoded Wishbone cycle
  typedef enum logic [1:0] {
    WB_OP_IDLE  = 2'd0,
    WB_OP_WRITE = 2'd1,
    WB_OP_READ  = 2'd2
  } wb_op_e;

  // Read tracker, one outstanding read at most
  typedef enum logic {
    RD_IDLE    = 1'b0,
    RD_PENDING = 1'b1
  } rd_state_e;

endpackage

`default_nettype wire

// File: hw/sdrc_fifo.sv
`default_nettype none

module sdrc_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic             wb_clk_i,
  input  logic             wb_rst_i,
  input  logic             push_i,
  input  logic [WIDTH-1:0] data_i,
  input  logic             pop_i,
  output logic [WIDTH-1:0] data_o,
  output logic             empty_o,
  output logic             full_o
);

  // Pointer and occupancy widths
  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  // Last slot, pointers wrap here
  localparam logic [PW-1:0] LAST_SLOT = PW'(DEPTH - 1);
  localparam logic [CW-1:0] FULL_CNT  = CW'(DEPTH);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PW-1:0]    wr_ptr;
  logic [PW-1:0]    rd_ptr;
  logic [CW-1:0]    count;
  logic             do_push;
  logic             do_pop;

  // ----------------------------------------
  // Status and qualified strobes
  // ----------------------------------------

  assign empty_o = (count == '0);
  assign full_o  = (count == FULL_CNT);

  // Push into full and pop from empty are dropped
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // Head word falls through, no read latency
  assign data_o = mem[rd_ptr];

  // ----------------------------------------
  // Storage
  // ----------------------------------------

  always_ff @(posedge wb_clk_i) begin
    if (do_push) begin
      mem[wr_ptr] <= data_i;
    end
  end

  // ----------------------------------------
  // Pointers and occupancy
  // ----------------------------------------

  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
      end
      // Count moves only when one side acts alone
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/wb_req_path.sv
`include "wb2sdrc_macros.svh"

`default_nettype none

module wb_req_path (
  input  logic                     wb_clk_i,
  input  logic                     wb_rst_i,
  // Strobes from the ack controller
  input  logic                     cmd_push_i,
  input  logic                     wr_push_i,
  // Wishbone request fields
  input  logic [`WB2SDRC_AW-1:0]   wb_addr_i,
  input  logic                     wb_we_i,
  input  logic [`WB2SDRC_DW-1:0]   wb_dat_i,
  input  logic [`WB2SDRC_DW/8-1:0] wb_sel_i,
  // Controller strobes
  input  logic                     sdr_req_ack_i,
  input  logic                     sdr_wr_next_i,
  // Queue status back to the ack controller
  output logic                     cmd_full_o,
  output logic                     wr_full_o,
  // SDRAM controller side
  output logic                     sdr_req_o,
  output wb2sdrc_pkg::sdr_cmd_t    sdr_cmd_o,
  output wb2sdrc_pkg::wr_beat_t    sdr_wr_o
);

  import wb2sdrc_pkg::*;

  sdr_cmd_t cmd_in;
  wr_beat_t beat_in;
  logic     cmd_empty;

  // ----------------------------------------
  // Payload packing
  // ----------------------------------------

  // Controller wants 0 for write
  assign cmd_in.wr_n = ~wb_we_i;
  assign cmd_in.addr = wb_addr_i;

  // Byte selects become active-low enables
  assign beat_in.en_n = ~wb_sel_i;
  assign beat_in.data = wb_dat_i;

  // ----------------------------------------
  // Command queue
  // ----------------------------------------

  // Popped when the controller takes the request
  sdrc_fifo #(
    .WIDTH ($bits(sdr_cmd_t)),
    .DEPTH (`WB2SDRC_CMD_DEPTH)
  ) u_cmd_fifo (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .push_i   (cmd_push_i),
    .data_i   (cmd_in),
    .pop_i    (sdr_req_ack_i),
    .data_o   (sdr_cmd_o),
    .empty_o  (cmd_empty),
    .full_o   (cmd_full_o)
  );

  // Request level held while anything is queued
  assign sdr_req_o = ~cmd_empty;

  // ----------------------------------------
  // Write-data queue
  // ----------------------------------------

  // Controller pulls one beat per sdr_wr_next_i
  sdrc_fifo #(
    .WIDTH ($bits(wr_beat_t)),
    .DEPTH (`WB2SDRC_WR_DEPTH)
  ) u_wr_fifo (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .push_i   (wr_push_i),
    .data_i   (beat_in),
    .pop_i    (sdr_wr_next_i),
    .data_o   (sdr_wr_o),
    .empty_o  (),
    .full_o   (wr_full_o)
  );

endmodule

`default_nettype wire

// File: hw/wb_rd_path.sv
`include "wb2sdrc_macros.svh"

`default_nettype none

module wb_rd_path (
  input  logic                   wb_clk_i,
  input  logic                   wb_rst_i,
  // Strobes from the ack controller
  input  logic                   rd_issue_i,
  input  logic                   rd_pop_i,
  // Read return from the SDRAM controller
  input  logic                   sdr_rd_valid_i,
  input  logic [`WB2SDRC_DW-1:0] sdr_rd_data_i,
  // Status back to the ack controller
  output logic                   rd_pending_o,
  output logic                   rd_avail_o,
  // Wishbone read data
  output logic [`WB2SDRC_DW-1:0] wb_dat_o
);

  import wb2sdrc_pkg::*;

  rd_state_e rd_state;
  logic      rd_empty;

  // ----------------------------------------
  // Pending-read tracker
  // ----------------------------------------

  // Set on issue, cleared when the data is acked
  // Issue wins if both arrive together
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      rd_state <= RD_IDLE;
    end else if (rd_issue_i) begin
      rd_state <= RD_PENDING;
    end else if (rd_pop_i) begin
      rd_state <= RD_IDLE;
    end
  end

  assign rd_pending_o = (rd_state == RD_PENDING);

  // ----------------------------------------
  // Read-return queue
  // ----------------------------------------

  // Filled by the controller, drained by the Wishbone ack
  sdrc_fifo #(
    .WIDTH (`WB2SDRC_DW),
    .DEPTH (`WB2SDRC_RD_DEPTH)
  ) u_rd_fifo (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .push_i   (sdr_rd_valid_i),
    .data_i   (sdr_rd_data_i),
    .pop_i    (rd_pop_i),
    .data_o   (wb_dat_o),
    .empty_o  (rd_empty),
    .full_o   ()
  );

  // Head word is ready for the ack
  assign rd_avail_o = ~rd_empty;

endmodule

`default_nettype wire

// File: hw/wb_ack_ctrl.sv
`default_nettype none

module wb_ack_ctrl (
  // Wishbone cycle
  input  logic wb_stb_i,
  input  logic wb_cyc_i,
  input  logic wb_we_i,
  // Path status
  input  logic cmd_full_i,
  input  logic wr_full_i,
  input  logic rd_pending_i,
  input  logic rd_avail_i,
  // Ack and queue strobes
  output logic wb_ack_o,
  output logic cmd_push_o,
  output logic wr_push_o,
  output logic rd_issue_o,
  output logic rd_pop_o
);

  import wb2sdrc_pkg::*;

  wb_op_e op;

  // ----------------------------------------
  // Cycle decode
  // ----------------------------------------

  always_comb begin
    if (wb_stb_i && wb_cyc_i) begin
      op = wb_we_i ? WB_OP_WRITE : WB_OP_READ;
    end else begin
      op = WB_OP_IDLE;
    end
  end

  // ----------------------------------------
  // Ack and strobes
  // ----------------------------------------

  always_comb begin
    wb_ack_o   = 1'b0;
    cmd_push_o = 1'b0;
    wr_push_o  = 1'b0;
    rd_issue_o = 1'b0;
    rd_pop_o   = 1'b0;
    case (op)
      // Posted write, acked once both queues have room
      WB_OP_WRITE: begin
        wb_ack_o   = !cmd_full_i && !wr_full_i;
        cmd_push_o = wb_ack_o;
        wr_push_o  = wb_ack_o;
      end
      // One read command per outstanding read
      // Ack waits for returned data
      WB_OP_READ: begin
        rd_issue_o = !cmd_full_i && !rd_pending_i;
        cmd_push_o = rd_issue_o;
        wb_ack_o   = rd_avail_i;
        rd_pop_o   = rd_avail_i;
      end
      default: begin
        wb_ack_o = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: hw/wb2sdrc_top.sv
`include "wb2sdrc_macros.svh"

`default_nettype none

module wb2sdrc_top (
  input  logic                     wb_clk_i,
  input  logic                     wb_rst_i,
  // ----------------------------------------
  // Wishbone classic slave
  // ----------------------------------------
  input  logic                     wb_stb_i,
  input  logic                     wb_cyc_i,
  input  logic                     wb_we_i,
  input  logic [`WB2SDRC_AW-1:0]   wb_addr_i,
  input  logic [`WB2SDRC_DW-1:0]   wb_dat_i,
  input  logic [`WB2SDRC_DW/8-1:0] wb_sel_i,
  output logic                     wb_ack_o,
  output logic [`WB2SDRC_DW-1:0]   wb_dat_o,
  // ----------------------------------------
  // SDRAM controller request side
  // ----------------------------------------
  output logic                     sdr_req_o,
  output wb2sdrc_pkg::sdr_cmd_t    sdr_cmd_o,
  input  logic                     sdr_req_ack_i,
  input  logic                     sdr_wr_next_i,
  output wb2sdrc_pkg::wr_beat_t    sdr_wr_o,
  input  logic                     sdr_rd_valid_i,
  input  logic [`WB2SDRC_DW-1:0]   sdr_rd_data_i
);

  // Ack controller to paths
  logic cmd_push;
  logic wr_push;
  logic rd_issue;
  logic rd_pop;
  // Paths back to ack controller
  logic cmd_full;
  logic wr_full;
  logic rd_pending;
  logic rd_avail;

  // Commands and write beats toward the controller
  wb_req_path u_req_path (
    .wb_clk_i      (wb_clk_i),
    .wb_rst_i      (wb_rst_i),
    .cmd_push_i    (cmd_push),
    .wr_push_i     (wr_push),
    .wb_addr_i     (wb_addr_i),
    .wb_we_i       (wb_we_i),
    .wb_dat_i      (wb_dat_i),
    .wb_sel_i      (wb_sel_i),
    .sdr_req_ack_i (sdr_req_ack_i),
    .sdr_wr_next_i (sdr_wr_next_i),
    .cmd_full_o    (cmd_full),
    .wr_full_o     (wr_full),
    .sdr_req_o     (sdr_req_o),
    .sdr_cmd_o     (sdr_cmd_o),
    .sdr_wr_o      (sdr_wr_o)
  );

  // Read tracking and returned data
  wb_rd_path u_rd_path (
    .wb_clk_i       (wb_clk_i),
    .wb_rst_i       (wb_rst_i),
    .rd_issue_i     (rd_issue),
    .rd_pop_i       (rd_pop),
    .sdr_rd_valid_i (sdr_rd_valid_i),
    .sdr_rd_data_i  (sdr_rd_data_i),
    .rd_pending_o   (rd_pending),
    .rd_avail_o     (rd_avail),
    .wb_dat_o       (wb_dat_o)
  );

  // Wishbone ack and queue strobes
  wb_ack_ctrl u_ack_ctrl (
    .wb_stb_i     (wb_stb_i),
    .wb_cyc_i     (wb_cyc_i),
    .wb_we_i      (wb_we_i),
    .cmd_full_i   (cmd_full),
    .wr_full_i    (wr_full),
    .rd_pending_i (rd_pending),
    .rd_avail_i   (rd_avail),
    .wb_ack_o     (wb_ack_o),
    .cmd_push_o   (cmd_push),
    .wr_push_o    (wr_push),
    .rd_issue_o   (rd_issue),
    .rd_pop_o     (rd_pop)
  );

endmodule

`default_nettype wire

// File: bench/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  timeunit 1ns;
  timeprecision 100ps;

  // 10 ns period
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Reset held for four rising edges
  initial begin
    rst_o = 1'b1;
    repeat (4) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

`default_nettype wire

// File: bench/tb_wb2sdrc.sv
`include "wb2sdrc_macros.svh"

`default_nettype none

module tb_wb2sdrc;

  timeunit 1ns;
  timeprecision 100ps;

  import wb2sdrc_pkg::*;

  localparam int DW      = `WB2SDRC_DW;
  localparam int AW      = `WB2SDRC_AW;
  localparam int SW      = `WB2SDRC_DW / 8;
  localparam int TIMEOUT = 200;

  logic          wb_clk;
  logic          wb_rst;
  logic          wb_stb;
  logic          wb_cyc;
  logic          wb_we;
  logic [AW-1:0] wb_addr;
  logic [DW-1:0] wb_dat;
  logic [SW-1:0] wb_sel;
  logic          wb_ack;
  logic [DW-1:0] wb_rdat;
  logic          sdr_req;
  sdr_cmd_t      sdr_cmd;
  logic          sdr_req_ack;
  logic          sdr_wr_next;
  wr_beat_t      sdr_wr;
  logic          sdr_rd_valid;
  logic [DW-1:0] sdr_rd_data;

  // Expected traffic toward the controller in issue order
  sdr_cmd_t      exp_cmds [$];
  wr_beat_t      exp_beats [$];
  // Shadow of acked writes and the model's own array
  logic [DW-1:0] shadow [logic [AW-1:0]];
  logic [DW-1:0] model_mem [logic [AW-1:0]];
  logic          hold_ack;
  int            rd_returned;
  int            rd_acked;
  logic [31:0]   stim_state;

  tb_clk_gen clk_gen_inst (
    .clk_o (wb_clk),
    .rst_o (wb_rst)
  );

  wb2sdrc_top wb2sdrc_top_inst (
    .wb_clk_i       (wb_clk),
    .wb_rst_i       (wb_rst),
    .wb_stb_i       (wb_stb),
    .wb_cyc_i       (wb_cyc),
    .wb_we_i        (wb_we),
    .wb_addr_i      (wb_addr),
    .wb_dat_i       (wb_dat),
    .wb_sel_i       (wb_sel),
    .wb_ack_o       (wb_ack),
    .wb_dat_o       (wb_rdat),
    .sdr_req_o      (sdr_req),
    .sdr_cmd_o      (sdr_cmd),
    .sdr_req_ack_i  (sdr_req_ack),
    .sdr_wr_next_i  (sdr_wr_next),
    .sdr_wr_o       (sdr_wr),
    .sdr_rd_valid_i (sdr_rd_valid),
    .sdr_rd_data_i  (sdr_rd_data)
  );

  // ----------------------------------------
  // Reference model
  // ----------------------------------------

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] stim_rand();
    stim_state = xorshift(stim_state);
    return stim_state;
  endfunction

  // Pattern for unwritten words tied to the full address
  function automatic logic [DW-1:0] fill_word(input logic [AW-1:0] addr);
    return DW'(addr) ^ DW'(32'hc3a5_9600);
  endfunction

  // Byte lanes with a low enable take the new data
  function automatic logic [DW-1:0] merge_bytes(input logic [DW-1:0] old_w,
      input logic [DW-1:0] new_w, input logic [SW-1:0] en_n);
    logic [DW-1:0] res;
    res = old_w;
    for (int b = 0; b < SW; b++) begin
      if (!en_n[b]) begin
        res[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return res;
  endfunction

  // Word a read must return
  function automatic logic [DW-1:0] ref_word(input logic [AW-1:0] addr);
    return shadow.exists(addr) ? shadow[addr] : fill_word(addr);
  endfunction

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic compare_cmd(input sdr_cmd_t got, input sdr_cmd_t exp);
    if (got !== exp) begin
      stop_run($sformatf("ERR %0t: command wr_n=%0b addr=%h, expected wr_n=%0b addr=%h",
                         $time, got.wr_n, got.addr, exp.wr_n, exp.addr));
    end
  endtask

  task automatic compare_beat(input wr_beat_t got, input wr_beat_t exp);
    if (got !== exp) begin
      stop_run($sformatf("ERR %0t: write beat en_n=%h data=%h, expected en_n=%h data=%h",
                         $time, got.en_n, got.data, exp.en_n, exp.data));
    end
  endtask

  task automatic compare_word(input logic [DW-1:0] got, input logic [DW-1:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("ERR %0t: read data %h, expected %h", $time, got, exp));
    end
  endtask

  task automatic compare_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("ERR %0t: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  // ----------------------------------------
  // Wishbone master
  // ----------------------------------------

  task automatic start_cycle(input logic we, input logic [AW-1:0] addr,
      input logic [DW-1:0] data, input logic [SW-1:0] sel);
    sdr_cmd_t cmd;
    wr_beat_t beat;
    @(posedge wb_clk);
    wb_stb  <= 1'b1;
    wb_cyc  <= 1'b1;
    wb_we   <= we;
    wb_addr <= addr;
    wb_dat  <= data;
    wb_sel  <= sel;
    // Every cycle owes exactly one command
    cmd.wr_n = ~we;
    cmd.addr = addr;
    exp_cmds.push_back(cmd);
    if (we) begin
      beat.en_n = ~sel;
      beat.data = data;
      exp_beats.push_back(beat);
    end
  endtask

  task automatic wait_ack(output logic [DW-1:0] data);
    int waited;
    waited = 0;
    do begin
      @(posedge wb_clk);
      waited++;
      if (waited > TIMEOUT) begin
        stop_run("Timeout: Wishbone cycle was never acknowledged");
      end
    end while (wb_ack !== 1'b1);
    data = wb_rdat;
    wb_stb <= 1'b0;
    wb_cyc <= 1'b0;
  endtask

  task automatic finish_write(input logic [AW-1:0] addr, input logic [DW-1:0] data,
      input logic [SW-1:0] sel);
    logic [DW-1:0] unused;
    wait_ack(unused);
    shadow[addr] = merge_bytes(ref_word(addr), data, ~sel);
  endtask

  task automatic wb_write(input logic [AW-1:0] addr, input logic [DW-1:0] data,
      input logic [SW-1:0] sel);
    start_cycle(1'b1, addr, data, sel);
    finish_write(addr, data, sel);
  endtask

  task automatic wb_read(input logic [AW-1:0] addr);
    logic [DW-1:0] got;
    start_cycle(1'b0, addr, '0, '1);
    wait_ack(got);
    if (rd_returned <= rd_acked) begin
      stop_run($sformatf("ERR %0t: read acked before the model returned data", $time));
    end
    rd_acked++;
    compare_word(got, ref_word(addr));
  endtask

  task automatic wait_queue_empty();
    int waited;
    waited = 0;
    while (sdr_req !== 1'b0) begin
      @(posedge wb_clk);
      waited++;
      if (waited > TIMEOUT) begin
        stop_run("Timeout: command queue never drained");
      end
    end
  endtask

  // ----------------------------------------
  // SDRAM controller model
  // ----------------------------------------

  initial begin : sdram_model
    sdr_cmd_t      cmd;
    wr_beat_t      beat;
    logic [DW-1:0] word;
    logic [31:0]   mstate;
    mstate = 32'd41448;
    sdr_req_ack  <= 1'b0;
    sdr_wr_next  <= 1'b0;
    sdr_rd_valid <= 1'b0;
    sdr_rd_data  <= '0;
    forever begin
      @(posedge wb_clk);
      mstate = xorshift(mstate);
      // Takes a waiting request on about one edge in four
      if (sdr_req === 1'b1 && !hold_ack && mstate[1:0] == 2'd0) begin
        cmd = sdr_cmd;
        if (exp_cmds.size() == 0) begin
          stop_run("Command appeared at the SDRAM side with no Wishbone cycle behind it");
        end
        compare_cmd(cmd, exp_cmds.pop_front());
        if (!cmd.wr_n) begin
          beat = sdr_wr;
          if (exp_beats.size() == 0) begin
            stop_run("Write command arrived with no write beat expected");
          end
          compare_beat(beat, exp_beats.pop_front());
          word = model_mem.exists(cmd.addr) ? model_mem[cmd.addr] : fill_word(cmd.addr);
          model_mem[cmd.addr] = merge_bytes(word, beat.data, beat.en_n);
        end
        sdr_req_ack <= 1'b1;
        sdr_wr_next <= ~cmd.wr_n;
        @(posedge wb_clk);
        sdr_req_ack <= 1'b0;
        sdr_wr_next <= 1'b0;
        if (cmd.wr_n) begin
          word = model_mem.exists(cmd.addr) ? model_mem[cmd.addr] : fill_word(cmd.addr);
          // Read latency of zero to seven extra cycles
          repeat (mstate[4:2]) @(posedge wb_clk);
          sdr_rd_valid <= 1'b1;
          sdr_rd_data  <= word;
          rd_returned++;
          @(posedge wb_clk);
          sdr_rd_valid <= 1'b0;
        end
      end
    end
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------

  initial begin : stimulus
    logic [31:0]   r;
    logic [AW-1:0] addr;
    sdr_cmd_t      held;
    int            waited;
    wb_stb      <= 1'b0;
    wb_cyc      <= 1'b0;
    wb_we       <= 1'b0;
    wb_addr     <= '0;
    wb_dat      <= '0;
    wb_sel      <= '0;
    hold_ack    = 1'b0;
    rd_returned = 0;
    rd_acked    = 0;
    stim_state  = 32'd41448;
    waited      = 0;
    do begin
      @(posedge wb_clk);
      waited++;
      if (waited > TIMEOUT) begin
        stop_run("Timeout: reset was never released");
      end
    end while (wb_rst !== 1'b0);

    // Quiet bus after reset
    repeat (3) begin
      @(posedge wb_clk);
      compare_flag(wb_ack, 1'b0, "wb_ack after reset");
      compare_flag(sdr_req, 1'b0, "sdr_req after reset");
    end

    // Full word then two lanes over it
    wb_write(26'h2a_0010, 32'h1122_3344, 4'hf);
    wb_write(26'h2a_0010, 32'haabb_ccdd, 4'b0101);
    wb_read(26'h2a_0010);

    // Mixed traffic over eight addresses
    for (int i = 0; i < 48; i++) begin
      r = stim_rand();
      addr = AW'(r[10:8] * 32'h0123_4567);
      if (r[1:0] != 2'd0) begin
        wb_write(addr, stim_rand(), SW'(r[15:12]));
      end else begin
        wb_read(addr);
      end
    end

    // Queue fills to its depth while the controller stalls
    wait_queue_empty();
    hold_ack <= 1'b1;
    for (int i = 0; i < `WB2SDRC_CMD_DEPTH; i++) begin
      wb_write(AW'(32'h0300_0040 + i * 4), stim_rand(), '1);
    end
    // First stalled write stays at the head
    held.wr_n = 1'b0;
    held.addr = AW'(32'h0300_0040);
    start_cycle(1'b1, 26'h030_0100, 32'h5a5a_0f0f, 4'b0011);
    repeat (8) begin
      @(posedge wb_clk);
      compare_flag(wb_ack, 1'b0, "wb_ack with a full command queue");
      compare_flag(sdr_req, 1'b1, "sdr_req with a full command queue");
      compare_cmd(sdr_cmd, held);
    end
    hold_ack <= 1'b0;
    finish_write(26'h030_0100, 32'h5a5a_0f0f, 4'b0011);
    wb_read(26'h030_0100);
    wb_read(26'h030_0040);

    wait_queue_empty();
    repeat (4) @(posedge wb_clk);
    if (exp_cmds.size() != 0 || exp_beats.size() != 0) begin
      stop_run("Expected commands or write beats never reached the SDRAM side");
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+hw
hw/wb2sdrc_pkg.sv
hw/sdrc_fifo.sv
hw/wb_req_path.sv
hw/wb_rd_path.sv
hw/wb_ack_ctrl.sv
hw/wb2sdrc_top.sv
bench/tb_clk_gen.sv
bench/tb_wb2sdrc.sv

// File: run_sim.sh
#!/bin/sh
# Compile with Verilator, run, then judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/100ps --top-module tb_wb2sdrc -f src.f \
  -o tb_wb2sdrc && ./obj_dir/tb_wb2sdrc > sim.log 2>&1
grep -qs "ALL CHECKS PASSED" sim.log && echo "simulation passed" || { echo "simulation failed, see sim.log"; exit 1; }
